//--- design/fdiv_fsqrt_pkg.sv
// binary32 only; rounding mode and flag encodings follow RISC-V, 5-bit tag by default
package fdiv_fsqrt_pkg;

  localparam int fp_width_gp       = 32;
  localparam int exp_width_gp      = 8;
  localparam int mant_width_gp     = 23;
  localparam int reg_addr_width_gp = 5;
  localparam int uexp_width_gp     = 10;  // unbiased exponent, signed
  localparam int q_width_gp        = 26;  // 24 kept bits, guard, one spare
  localparam int exp_bias_gp       = 127;

  localparam logic [fp_width_gp-1:0] canon_nan_gp = 32'h7fc0_0000;

  typedef enum logic [2:0] {
    rne = 3'd0,
    rtz = 3'd1,
    rdn = 3'd2,
    rup = 3'd3,
    rmm = 3'd4
  } frm_e;

  typedef enum logic {
    op_fdiv  = 1'b0,
    op_fsqrt = 1'b1
  } fp_op_e;

  typedef enum logic [2:0] {
    cls_zero,
    cls_normal,
    cls_inf,
    cls_snan,
    cls_qnan
  } fp_class_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic nv;  // invalid
    logic dz;  // divide by zero
    logic of;
    logic uf;
    logic nx;
  } fflags_s;

  typedef struct packed {
    logic                            sign;
    logic signed [uexp_width_gp-1:0] exp;   // bias removed
    logic [mant_width_gp:0]          mant;  // hidden one at msb
    fp_class_e                       cls;
  } fp_unpacked_s;

  typedef struct packed {
    fp_op_e                 op;
    frm_e                   rm;
    logic [fp_width_gp-1:0] a;
    logic [fp_width_gp-1:0] b;
  } ds_req_s;

  typedef struct packed {
    logic [fp_width_gp-1:0] result;
    fflags_s                flags;
  } ds_resp_s;

endpackage

//--- design/fp_unpack.sv
// subnormal operands are read as signed zero; NaN payloads are not kept
module fp_unpack (
  input  logic [fdiv_fsqrt_pkg::fp_width_gp-1:0] operand_i
  , output fdiv_fsqrt_pkg::fp_unpacked_s         unpacked_o
);

  import fdiv_fsqrt_pkg::*;

  logic [exp_width_gp-1:0]  exp_field;
  logic [mant_width_gp-1:0] frac_field;
  logic                     exp_zero;
  logic                     exp_ones;

  assign exp_field  = operand_i[fp_width_gp-2 -: exp_width_gp];
  assign frac_field = operand_i[mant_width_gp-1:0];
  assign exp_zero   = (exp_field == '0);
  assign exp_ones   = (exp_field == '1);

  always_comb begin
    unpacked_o.sign = operand_i[fp_width_gp-1];
    // two's complement in the narrow width, read back as signed
    unpacked_o.exp  = $signed(uexp_width_gp'(exp_field) - uexp_width_gp'(exp_bias_gp));
    unpacked_o.mant = {1'b1, frac_field};  // hidden bit restored

    if (exp_zero) begin
      unpacked_o.cls  = cls_zero;       // covers subnormals too
      unpacked_o.mant = '0;
    end else if (!exp_ones) begin
      unpacked_o.cls = cls_normal;
    end else if (frac_field == '0) begin
      unpacked_o.cls = cls_inf;
    end else if (frac_field[mant_width_gp-1]) begin
      unpacked_o.cls = cls_qnan;        // quiet bit set
    end else begin
      unpacked_o.cls = cls_snan;
    end
  end

endmodule

//--- design/mant_divsqrt_iter.sv
// one radix-2 digit per cycle; start_i is ignored while a run is in progress
module mant_divsqrt_iter (
  input  logic                                     clk_i
  , input  logic                                   reset_i
  , input  logic                                   start_i
  , input  fdiv_fsqrt_pkg::fp_op_e                 op_i
  , input  logic [fdiv_fsqrt_pkg::q_width_gp-1:0]  num_i
  , input  logic [fdiv_fsqrt_pkg::mant_width_gp:0] den_i
  , output logic                                   idle_o
  , output logic                                   done_o
  , output logic [fdiv_fsqrt_pkg::q_width_gp-1:0]  q_o
  , output logic                                   sticky_o
);

  import fdiv_fsqrt_pkg::*;

  localparam int den_width_lp = mant_width_gp + 1;
  localparam int rem_width_lp = q_width_gp + 1;    // sqrt remainder stays below 2*root+1
  localparam int cur_width_lp = rem_width_lp + 2;  // remainder with next radicand pair
  localparam int cnt_width_lp = $clog2(q_width_gp);

  typedef enum logic {
    st_idle,
    st_run
  } iter_state_e;

  iter_state_e             state_r;
  logic [cnt_width_lp-1:0] cnt_r;
  logic                    done_r;
  logic                    last_step;

  fp_op_e                  op_r;
  logic [den_width_lp-1:0] den_r;
  logic [rem_width_lp-1:0] rem_r;
  logic [q_width_gp-1:0]   q_r;
  logic [q_width_gp-1:0]   rad_r;  // radicand bits not yet consumed

  logic [cur_width_lp-1:0] cur;
  logic [cur_width_lp-1:0] sub;
  logic [cur_width_lp-1:0] kept;
  logic                    ge;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // shared trial subtraction

  always_comb begin
    if (op_r == op_fdiv) begin
      cur = cur_width_lp'(rem_r);  // compare first, shift after
      sub = cur_width_lp'(den_r);
    end else begin
      cur = {rem_r, rad_r[q_width_gp-1 -: 2]};     // bring down one pair
      sub = cur_width_lp'({q_r, 2'b01});           // 4*root + 1
    end
    ge   = (cur >= sub);
    kept = ge ? cur - sub : cur;  // restoring step
  end

  assign last_step = (cnt_r == cnt_width_lp'(q_width_gp - 1));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_idle;
      cnt_r   <= '0;
      done_r  <= 1'b0;
    end else begin
      done_r <= 1'b0;
      case (state_r)
        st_idle: begin
          if (start_i) begin
            state_r <= st_run;
            cnt_r   <= '0;
          end
        end
        st_run: begin
          cnt_r <= cnt_r + 1'b1;
          if (last_step) begin
            state_r <= st_idle;
            done_r  <= 1'b1;  // q_r now holds all bits
          end
        end
        default: state_r <= st_idle;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath

  always_ff @(posedge clk_i) begin
    if (state_r == st_idle && start_i) begin
      op_r  <= op_i;
      den_r <= den_i;
      rad_r <= num_i;
      rem_r <= (op_i == op_fdiv) ? rem_width_lp'(num_i) : '0;
      q_r   <= '0;
    end else if (state_r == st_run) begin
      q_r   <= {q_r[q_width_gp-2:0], ge};
      rad_r <= {rad_r[q_width_gp-3:0], 2'b00};  // zeros after the top half
      if (op_r == op_fdiv) begin
        rem_r <= rem_width_lp'({kept, 1'b0});
      end else begin
        rem_r <= rem_width_lp'(kept);
      end
    end
  end

  assign idle_o   = (state_r == st_idle);
  assign done_o   = done_r;
  assign q_o      = q_r;
  assign sticky_o = |rem_r;  // exact iff nothing left over

endmodule

//--- design/fp_round_pack.sv
// q_i bit 25 carries weight one at exp_i; tiny results flush to zero, no subnormal output
module fp_round_pack (
  input  logic                                            sign_i
  , input  logic signed [fdiv_fsqrt_pkg::uexp_width_gp-1:0] exp_i
  , input  logic [fdiv_fsqrt_pkg::q_width_gp-1:0]         q_i
  , input  logic                                          sticky_i
  , input  fdiv_fsqrt_pkg::frm_e                          rm_i
  , output fdiv_fsqrt_pkg::ds_resp_s                      resp_o
);

  import fdiv_fsqrt_pkg::*;

  localparam logic signed [uexp_width_gp-1:0] exp_inf_lp =
    uexp_width_gp'(2**exp_width_gp - 1);

  logic [mant_width_gp:0]          mant;      // 24 kept bits
  logic                            guard;
  logic                            rest;      // everything below guard
  logic signed [uexp_width_gp-1:0] exp_norm;
  logic                            inexact;
  logic                            round_up;
  logic [mant_width_gp+1:0]        mant_rnd;  // with carry out
  logic signed [uexp_width_gp-1:0] exp_biased;
  logic                            ovf_to_inf;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    if (q_i[q_width_gp-1]) begin
      mant     = q_i[q_width_gp-1 -: mant_width_gp+1];
      guard    = q_i[1];
      rest     = q_i[0] | sticky_i;
      exp_norm = exp_i;
    end else begin
      mant     = q_i[q_width_gp-2 -: mant_width_gp+1];  // one left shift
      guard    = q_i[0];
      rest     = sticky_i;
      exp_norm = exp_i - 1'b1;
    end

    inexact = guard | rest;
    case (rm_i)
      rne:     round_up = guard & (rest | mant[0]);  // ties to even
      rtz:     round_up = 1'b0;
      rdn:     round_up = inexact & sign_i;
      rup:     round_up = inexact & ~sign_i;
      rmm:     round_up = guard;
      default: round_up = 1'b0;
    endcase

    mant_rnd   = {1'b0, mant} + round_up;
    exp_biased = exp_norm + uexp_width_gp'(exp_bias_gp) + mant_rnd[mant_width_gp+1];

    ovf_to_inf = (rm_i == rne) || (rm_i == rmm) ||
                 ((rm_i == rup) && !sign_i) || ((rm_i == rdn) && sign_i);

    resp_o.flags = '0;
    if (exp_biased >= exp_inf_lp) begin
      if (ovf_to_inf) begin
        resp_o.result = {sign_i, {exp_width_gp{1'b1}}, {mant_width_gp{1'b0}}};
      end else begin
        resp_o.result = {sign_i, {(exp_width_gp-1){1'b1}}, 1'b0, {mant_width_gp{1'b1}}};
      end
      resp_o.flags.of = 1'b1;
      resp_o.flags.nx = 1'b1;
    end else if (exp_biased <= 0) begin
      resp_o.result   = {sign_i, {(fp_width_gp-1){1'b0}}};  // flushed
      resp_o.flags.uf = 1'b1;
      resp_o.flags.nx = 1'b1;
    end else begin
      // a carry leaves the fraction bits at zero
      resp_o.result   = {sign_i, exp_biased[exp_width_gp-1:0], mant_rnd[mant_width_gp-1:0]};
      resp_o.flags.nx = inexact;
    end
  end

endmodule

//--- design/divsqrt_core.sv
// one operation at a time; req_i is sampled only on start_i while idle
module divsqrt_core (
  input  logic                        clk_i
  , input  logic                      reset_i
  , input  logic                      start_i
  , input  fdiv_fsqrt_pkg::ds_req_s   req_i
  , output logic                      idle_o
  , output logic                      done_o
  , output fdiv_fsqrt_pkg::ds_resp_s  resp_o
);

  import fdiv_fsqrt_pkg::*;

  typedef enum logic [1:0] {
    cs_idle,
    cs_iter,
    cs_round,
    cs_done
  } core_state_e;

  core_state_e                     state_r;
  logic                            dec_r;  // first cycle after start
  ds_req_s                         req_r;
  ds_resp_s                        resp_r;

  fp_unpacked_s                    ua;
  fp_unpacked_s                    ub;
  logic                            is_div;
  logic                            a_nan;
  logic                            b_nan;
  logic                            special;
  ds_resp_s                        spec_resp;
  logic                            res_sign;
  logic signed [uexp_width_gp-1:0] res_exp;
  logic [q_width_gp-1:0]           num;

  logic                            iter_start;
  logic                            iter_idle;
  logic                            iter_done;
  logic [q_width_gp-1:0]           iter_q;
  logic                            iter_sticky;
  ds_resp_s                        rnd_resp;

  fp_unpack i_unpack_a (.operand_i(req_r.a), .unpacked_o(ua));
  fp_unpack i_unpack_b (.operand_i(req_r.b), .unpacked_o(ub));

  assign is_div   = (req_r.op == op_fdiv);
  assign a_nan    = ua.cls inside {cls_qnan, cls_snan};
  assign b_nan    = ub.cls inside {cls_qnan, cls_snan};
  assign res_sign = is_div ? (ua.sign ^ ub.sign) : 1'b0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fixed results for special operands

  always_comb begin
    special          = 1'b1;
    spec_resp.result = canon_nan_gp;
    spec_resp.flags  = '0;
    if (is_div) begin
      if (a_nan || b_nan) begin
        spec_resp.flags.nv = (ua.cls == cls_snan) || (ub.cls == cls_snan);
      end else if ((ua.cls == ub.cls) && (ua.cls inside {cls_zero, cls_inf})) begin
        spec_resp.flags.nv = 1'b1;  // 0/0, inf/inf
      end else if ((ua.cls == cls_inf) || (ub.cls == cls_zero)) begin
        spec_resp.result   = {res_sign, {exp_width_gp{1'b1}}, {mant_width_gp{1'b0}}};
        spec_resp.flags.dz = (ua.cls != cls_inf);
      end else if ((ua.cls == cls_zero) || (ub.cls == cls_inf)) begin
        spec_resp.result = {res_sign, {(fp_width_gp-1){1'b0}}};
      end else begin
        special = 1'b0;
      end
    end else begin
      if (a_nan) begin
        spec_resp.flags.nv = (ua.cls == cls_snan);
      end else if (ua.cls == cls_zero) begin
        spec_resp.result = {ua.sign, {(fp_width_gp-1){1'b0}}};  // keeps -0
      end else if (ua.sign) begin
        spec_resp.flags.nv = 1'b1;
      end else if (ua.cls == cls_inf) begin
        spec_resp.result = {1'b0, {exp_width_gp{1'b1}}, {mant_width_gp{1'b0}}};
      end else begin
        special = 1'b0;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operand alignment

  assign res_exp = is_div ? (ua.exp - ub.exp) : (ua.exp >>> 1);

  always_comb begin
    if (is_div) begin
      num = {2'b00, ua.mant};
    end else if (ua.exp[0]) begin
      num = {ua.mant, 2'b00};        // odd exponent, radicand doubled
    end else begin
      num = {1'b0, ua.mant, 1'b0};
    end
  end

  assign iter_start = (state_r == cs_iter) && dec_r && !special && iter_idle;

  mant_divsqrt_iter i_iter (
    .clk_i    (clk_i)
    , .reset_i  (reset_i)
    , .start_i  (iter_start)
    , .op_i     (req_r.op)
    , .num_i    (num)
    , .den_i    (ub.mant)
    , .idle_o   (iter_idle)
    , .done_o   (iter_done)
    , .q_o      (iter_q)
    , .sticky_o (iter_sticky)
  );

  fp_round_pack i_round (
    .sign_i     (res_sign)
    , .exp_i    (res_exp)
    , .q_i      (iter_q)
    , .sticky_i (iter_sticky)
    , .rm_i     (req_r.rm)
    , .resp_o   (rnd_resp)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= cs_idle;
      dec_r   <= 1'b0;
    end else begin
      dec_r <= 1'b0;
      case (state_r)
        cs_idle: begin
          if (start_i) begin
            state_r <= cs_iter;
            dec_r   <= 1'b1;
          end
        end
        cs_iter: begin
          if ((dec_r && special) || iter_done) begin
            state_r <= cs_round;
          end
        end
        cs_round: state_r <= cs_done;
        cs_done:  state_r <= cs_idle;
        default:  state_r <= cs_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_r == cs_idle) && start_i) begin
      req_r <= req_i;
    end
    if (state_r == cs_round) begin
      resp_r <= special ? spec_resp : rnd_resp;  // held until next start
    end
  end

  assign idle_o = (state_r == cs_idle) && iter_idle;
  assign done_o = (state_r == cs_done);
  assign resp_o = resp_r;

endmodule

//--- design/fpu_fdiv_fsqrt.sv
// one request in flight; resp_o and rd_o are meaningful only while v_o is high
module fpu_fdiv_fsqrt #(
  parameter int reg_addr_width_p = fdiv_fsqrt_pkg::reg_addr_width_gp
) (
  input  logic                          clk_i
  , input  logic                        reset_i

  , input  logic                        v_i
  , input  fdiv_fsqrt_pkg::ds_req_s     req_i
  , input  logic [reg_addr_width_p-1:0] rd_i
  , output logic                        ready_o

  , output logic                        v_o
  , output fdiv_fsqrt_pkg::ds_resp_s    resp_o
  , output logic [reg_addr_width_p-1:0] rd_o
  , input  logic                        yumi_i
);

  typedef enum logic [1:0] {
    st_idle,
    st_busy,
    st_done
  } ds_state_e;

  ds_state_e                   state_r;
  ds_state_e                   state_n;
  logic [reg_addr_width_p-1:0] rd_r;
  logic                        accept;
  logic                        core_idle;
  logic                        core_done;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // divide / sqrt engine

  divsqrt_core i_core (
    .clk_i     (clk_i)
    , .reset_i (reset_i)
    , .start_i (accept)
    , .req_i   (req_i)
    , .idle_o  (core_idle)
    , .done_o  (core_done)
    , .resp_o  (resp_o)  // registered in the core
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request / response handshake

  assign ready_o = (state_r == st_idle) && core_idle;  // independent of v_i
  assign accept  = ready_o && v_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      st_idle: begin
        if (accept) begin
          state_n = st_busy;
        end
      end
      st_busy: begin
        if (core_done) begin
          state_n = st_done;  // done pulse becomes a held valid
        end
      end
      st_done: begin
        if (yumi_i) begin
          state_n = st_idle;
        end
      end
      default: state_n = st_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_idle;
    end else begin
      state_r <= state_n;
    end
  end

  // tag travels alongside the operation
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rd_r <= rd_i;
    end
  end

  assign v_o  = (state_r == st_done);
  assign rd_o = rd_r;

endmodule

//--- verification/fdiv_fsqrt_model.svh
// integer reference model; include after importing fdiv_fsqrt_pkg, subnormals count as zero
`ifndef fdiv_fsqrt_model_svh
`define fdiv_fsqrt_model_svh

function automatic bit op_is_nan(input logic [31:0] x);
  return (x[30:23] == 8'hff) && (x[22:0] != '0);
endfunction

function automatic bit op_is_snan(input logic [31:0] x);
  return op_is_nan(x) && !x[22];  // quiet bit clear
endfunction

function automatic bit op_is_inf(input logic [31:0] x);
  return (x[30:23] == 8'hff) && (x[22:0] == '0);
endfunction

function automatic bit op_is_zero(input logic [31:0] x);
  return (x[30:23] == 8'h00);  // subnormals too
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed results, returns 0 for ordinary operands
function automatic bit special_result(input ds_req_s req, output ds_resp_s resp);
  logic s;
  s           = req.a[31] ^ req.b[31];
  resp.result = 32'h7fc0_0000;
  resp.flags  = '0;
  if (req.op == op_fsqrt) begin
    if (op_is_nan(req.a)) resp.flags.nv = op_is_snan(req.a);
    else if (op_is_zero(req.a)) resp.result = {req.a[31], 31'd0};  // sqrt(-0) is -0
    else if (req.a[31]) resp.flags.nv = 1'b1;
    else if (op_is_inf(req.a)) resp.result = 32'h7f80_0000;
    else return 1'b0;
    return 1'b1;
  end
  if (op_is_nan(req.a) || op_is_nan(req.b)) begin
    resp.flags.nv = op_is_snan(req.a) || op_is_snan(req.b);
  end else if ((op_is_zero(req.a) && op_is_zero(req.b)) ||
               (op_is_inf(req.a) && op_is_inf(req.b))) begin
    resp.flags.nv = 1'b1;
  end else if (op_is_inf(req.a)) begin
    resp.result = {s, 8'hff, 23'd0};
  end else if (op_is_zero(req.b)) begin
    resp.result   = {s, 8'hff, 23'd0};
    resp.flags.dz = 1'b1;
  end else if (op_is_zero(req.a) || op_is_inf(req.b)) begin
    resp.result = {s, 31'd0};
  end else begin
    return 1'b0;
  end
  return 1'b1;
endfunction

function automatic bit is_special(input ds_req_s req);
  ds_resp_s dummy_resp;
  return special_result(req, dummy_resp);
endfunction

function automatic logic [63:0] int_sqrt(input logic [63:0] x);
  logic [63:0] r;
  logic [63:0] t;
  r = '0;
  for (int i = 31; i >= 0; i--) begin
    t = r | (64'd1 << i);
    if (t * t <= x) r = t;
  end
  return r;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// q carries weight one at bit 25, value in [0.5, 2)
function automatic ds_resp_s round_result(input logic sign, input int e_unb,
                                          input logic [25:0] q, input bit sticky,
                                          input frm_e rm);
  ds_resp_s    r;
  int          sh;
  int          e_b;
  logic [25:0] low;
  logic [24:0] sig;
  bit          guard;
  bit          rest;
  bit          up;
  sh    = q[25] ? 2 : 1;
  e_b   = e_unb + 127 - (q[25] ? 0 : 1);
  sig   = 25'(q >> sh);
  low   = q & ((26'd1 << sh) - 1);
  guard = low[sh-1];
  rest  = sticky || ((low & ((26'd1 << (sh - 1)) - 1)) != '0);
  case (rm)
    rne:     up = guard && (rest || sig[0]);
    rtz:     up = 1'b0;
    rdn:     up = sign && (guard || rest);
    rup:     up = !sign && (guard || rest);
    default: up = guard;  // rmm, ties away
  endcase
  sig = sig + up;
  if (sig[24]) begin
    sig = sig >> 1;
    e_b++;
  end
  r.flags = '0;
  if (e_b >= 255) begin
    r.flags.of = 1'b1;
    r.flags.nx = 1'b1;
    if (rm == rne || rm == rmm || (rm == rup && !sign) || (rm == rdn && sign))
      r.result = {sign, 8'hff, 23'd0};
    else
      r.result = {sign, 8'hfe, {23{1'b1}}};  // largest finite
  end else if (e_b <= 0) begin
    r.result   = {sign, 31'd0};
    r.flags.uf = 1'b1;
    r.flags.nx = 1'b1;
  end else begin
    r.result   = {sign, e_b[7:0], sig[22:0]};
    r.flags.nx = guard || rest;
  end
  return r;
endfunction

function automatic ds_resp_s expected_resp(input ds_req_s req);
  ds_resp_s    r;
  logic [63:0] ma;
  logic [63:0] mb;
  logic [63:0] num;
  logic [63:0] q;
  int          ea;
  int          eb;
  int          e;
  bit          sticky;
  logic        sign;
  if (special_result(req, r)) return r;
  ma = {40'd0, 1'b1, req.a[22:0]};
  mb = {40'd0, 1'b1, req.b[22:0]};
  ea = int'(req.a[30:23]) - 127;
  eb = int'(req.b[30:23]) - 127;
  if (req.op == op_fdiv) begin
    num    = ma << 25;
    q      = num / mb;
    sticky = (num % mb) != '0;
    e      = ea - eb;
    sign   = req.a[31] ^ req.b[31];
  end else begin
    num    = (ea % 2 != 0) ? (ma << 28) : (ma << 27);  // odd exponent moves into radicand
    q      = int_sqrt(num);
    sticky = (q * q) != num;
    e      = (ea % 2 != 0) ? (ea - 1) / 2 : ea / 2;
    sign   = 1'b0;
  end
  return round_result(sign, e, q[25:0], sticky, req.rm);
endfunction

`endif

//--- verification/tb_fpu_fdiv_fsqrt.sv
// fixed seed, one request in flight; responses are expected in request order
module tb_fpu_fdiv_fsqrt;

  timeunit 1ns;
  timeprecision 1ps;

  import fdiv_fsqrt_pkg::*;

  `include "fdiv_fsqrt_model.svh"

  localparam int rd_width_lp       = reg_addr_width_gp;
  localparam int n_req_lp          = 300;
  localparam int cycles_per_req_lp = 40;
  localparam int margin_cycles_lp  = 2000;
  localparam int clk_period_lp     = 100;

  logic                   clk_i;
  logic                   reset_i;
  logic                   v_i;
  ds_req_s                req_i;
  logic [rd_width_lp-1:0] rd_i;
  logic                   ready_o;
  logic                   v_o;
  ds_resp_s               resp_o;
  logic [rd_width_lp-1:0] rd_o;
  logic                   yumi_i;

  integer                 seed;
  int                     cycle_cnt = 0;
  bit                     v_seen    = 1'b0;
  bit                     ready_due = 1'b0;  // ready expected at next negedge
  ds_resp_s               held_resp;
  logic [rd_width_lp-1:0] held_rd;

  ds_req_s                dir_q[$];
  ds_resp_s               exp_resp_q[$];
  logic [rd_width_lp-1:0] exp_rd_q[$];
  int                     exp_lat_q[$];
  int                     acc_cyc_q[$];

  fpu_fdiv_fsqrt #(.reg_addr_width_p(rd_width_lp)) i_fpu_fdiv_fsqrt (
    .clk_i     (clk_i)
    , .reset_i (reset_i)
    , .v_i     (v_i)
    , .req_i   (req_i)
    , .rd_i    (rd_i)
    , .ready_o (ready_o)
    , .v_o     (v_o)
    , .resp_o  (resp_o)
    , .rd_o    (rd_o)
    , .yumi_i  (yumi_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] observed,
                             input logic [63:0] expected);
    if (observed !== expected) begin
      abort_run($sformatf("CHECK FAILED at %0d ns: %s observed 0x%0h expected 0x%0h",
                          $time, name, observed, expected));
    end
  endtask

  task automatic add_directed(input fp_op_e op, input frm_e rm, input logic [31:0] a,
                              input logic [31:0] b);
    ds_req_s r;
    r = {op, rm, a, b};
    dir_q.push_back(r);
  endtask

  task automatic draw_normal(input bit wide, output logic [31:0] x);
    logic [7:0] e;
    e = wide ? 8'(1 + {$random(seed)} % 254) : 8'(100 + {$random(seed)} % 55);
    x = {1'($random(seed)), e, 23'($random(seed))};
  endtask

  task automatic build_directed();
    logic [31:0] tiny;
    add_directed(op_fdiv, rne, 32'h0000_0000, 32'h0000_0000);   // 0/0
    add_directed(op_fdiv, rne, 32'h7f80_0000, 32'hff80_0000);   // inf/inf
    add_directed(op_fdiv, rne, 32'h3f80_0000, 32'h0000_0000);   // x/0
    add_directed(op_fdiv, rtz, 32'hbf80_0000, 32'h0000_0000);
    add_directed(op_fdiv, rne, 32'h0000_0000, 32'h4000_0000);
    add_directed(op_fdiv, rdn, 32'h8000_0000, 32'h4000_0000);
    add_directed(op_fdiv, rne, 32'h7f80_0000, 32'hc000_0000);
    add_directed(op_fdiv, rup, 32'h4000_0000, 32'h7f80_0000);
    add_directed(op_fdiv, rne, 32'h7fc0_0000, 32'h3f80_0000);   // quiet NaN
    add_directed(op_fdiv, rne, 32'h3f80_0000, 32'h7f80_0001);   // signaling NaN
    add_directed(op_fdiv, rne, 32'h0000_0001, 32'h3f80_0000);   // subnormal in
    add_directed(op_fdiv, rne, 32'h3f80_0000, 32'h4040_0000);   // 1/3
    add_directed(op_fsqrt, rne, 32'h0000_0000, '0);
    add_directed(op_fsqrt, rne, 32'h8000_0000, '0);
    add_directed(op_fsqrt, rne, 32'hbf80_0000, '0);             // negative
    add_directed(op_fsqrt, rne, 32'h7f80_0000, '0);
    add_directed(op_fsqrt, rne, 32'hff80_0000, '0);
    add_directed(op_fsqrt, rne, 32'hffc0_0000, '0);
    add_directed(op_fsqrt, rne, 32'h7fa0_0000, '0);
    add_directed(op_fsqrt, rup, 32'h4080_0000, '0);             // exact root
    // both signs under every mode
    for (int m = 0; m < 10; m++) begin
      tiny = {m >= 5, 31'h0080_0000};
      add_directed(op_fdiv, frm_e'(m % 5), 32'h7f00_0000, tiny);  // overflow
      add_directed(op_fdiv, frm_e'(m % 5), tiny, 32'h7f00_0000);  // underflow
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : stimulus
    ds_req_s                r;
    logic [rd_width_lp-1:0] tag;
    bit                     wide;
    seed    = 44;
    reset_i = 1'b1;
    v_i     = 1'b0;
    req_i   = '0;
    rd_i    = '0;
    yumi_i  = 1'b0;
    build_directed();
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    for (int n = 0; n < n_req_lp; n++) begin
      if (n < dir_q.size()) begin
        r = dir_q[n];
      end else begin
        wide = ({$random(seed)} % 2) != 0;
        r.op = ({$random(seed)} % 2 != 0) ? op_fsqrt : op_fdiv;
        r.rm = frm_e'(3'({$random(seed)} % 5));
        draw_normal(wide, r.a);
        draw_normal(wide, r.b);
        if (r.op == op_fsqrt) r.a[31] = 1'b0;  // negatives covered above
      end
      tag = rd_width_lp'($random(seed));
      @(posedge clk_i);
      v_i   <= 1'b1;
      req_i <= r;
      rd_i  <= tag;
      do @(negedge clk_i); while (!ready_o);
      @(posedge clk_i);  // accepted here
      v_i <= 1'b0;
    end
    while (exp_resp_q.size() != 0) @(negedge clk_i);
    repeat (2) @(negedge clk_i);
    check_value("ready_o when idle", ready_o, 1'b1);
    check_value("v_o when idle", v_o, 1'b0);
    $display("Test OK");
    $finish;
  end

  // random back-pressure
  initial begin : consumer
    int hold;
    hold = 0;
    while (reset_i !== 1'b0) @(negedge clk_i);
    forever begin
      @(negedge clk_i);
      if (yumi_i) begin
        @(posedge clk_i);
        yumi_i <= 1'b0;
        hold = {$random(seed)} % 8;
      end else if (v_o) begin
        if (hold == 0) begin
          @(posedge clk_i);
          yumi_i <= 1'b1;
        end else begin
          hold--;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // all outputs sampled mid-cycle
  always @(negedge clk_i) begin
    ds_resp_s er;
    if (!reset_i) begin
      if (v_i && ready_o) begin  // accepted at the coming edge
        exp_resp_q.push_back(expected_resp(req_i));
        exp_rd_q.push_back(rd_i);
        exp_lat_q.push_back(is_special(req_i) ? 3 : 30);
        acc_cyc_q.push_back(cycle_cnt + 1);
      end
      if (v_seen && !v_o && !ready_due) begin
        abort_run("v_o went low before the response was taken with yumi_i");
      end
      if (ready_due) begin
        check_value("ready_o after yumi", ready_o, 1'b1);
        ready_due = 1'b0;
      end
      if (v_o && !v_seen) begin  // rose at the last edge
        if (exp_resp_q.size() == 0) begin
          abort_run("v_o went high with no request outstanding");
        end else begin
          er = exp_resp_q[0];
          check_value("latency", cycle_cnt - acc_cyc_q[0], exp_lat_q[0]);
          check_value("resp_o.result", resp_o.result, er.result);
          check_value("resp_o.flags", resp_o.flags, er.flags);
          check_value("rd_o", rd_o, exp_rd_q[0]);
          held_resp = resp_o;
          held_rd   = rd_o;
        end
      end
      if (v_o) begin
        check_value("resp_o held", resp_o, held_resp);
        check_value("rd_o held", rd_o, held_rd);
        check_value("ready_o while v_o", ready_o, 1'b0);
      end
      if (v_o && yumi_i) begin  // consumed at the coming edge
        void'(exp_resp_q.pop_front());
        void'(exp_rd_q.pop_front());
        void'(exp_lat_q.pop_front());
        void'(acc_cyc_q.pop_front());
        ready_due = 1'b1;
      end
      v_seen = v_o;
    end
  end

  initial begin : watchdog
    #((n_req_lp * cycles_per_req_lp + margin_cycles_lp) * clk_period_lp);
    abort_run("timeout: not all requests completed in the expected number of cycles");
  end

endmodule

//--- build.f
design/fdiv_fsqrt_pkg.sv
design/fp_unpack.sv
design/mant_divsqrt_iter.sv
design/fp_round_pack.sv
design/divsqrt_core.sv
design/fpu_fdiv_fsqrt.sv
+incdir+verification
verification/tb_fpu_fdiv_fsqrt.sv
